// ==== Makefile ====
VERILATOR ?= verilator
FLAGS     ?= --timing --assert
TOP       ?= mc_bridge_tb
FILELIST  ?= tb.f
OBJ_DIR   ?= obj_dir

.PHONY: lint sim clean

lint:
	$(VERILATOR) --lint-only $(FLAGS) -f $(FILELIST) --top-module $(TOP)

sim:
	$(VERILATOR) --binary $(FLAGS) -f $(FILELIST) --top-module $(TOP) --Mdir $(OBJ_DIR)
	@out="$$(./$(OBJ_DIR)/V$(TOP))"; \
	echo "$$out"; \
	echo "$$out" | grep -qx "All tests passed"

clean:
	rm -rf $(OBJ_DIR)

// ==== rtl/mc_addr_xlate.sv ====
`timescale 1ns/10ps

`include "mc_bridge_macros.svh"

module mc_addr_xlate
  (input        [`MC_PADDR_W-1:0] paddr_i
   , output logic [`MC_X_W-1:0]   x_o
   , output logic [`MC_Y_W-1:0]   y_o
   , output logic [`MC_ADDR_W-1:0] addr_o
   );

  // word offset inside one vcache block
  localparam int OFFSET_W = $clog2(`MC_VCACHE_BLOCK_WORDS);
  // one bank per column on each of the two vcache rows
  localparam int BANK_W = $clog2(2 * `MC_NUM_TILES_X);
  localparam int UPPER_LSB = 2 + OFFSET_W + BANK_W;
  localparam int UPPER_W = `MC_PADDR_W - UPPER_LSB;

  logic                is_dram;
  logic [OFFSET_W-1:0] word_offset;
  logic [BANK_W-1:0]   bank;
  logic [UPPER_W-1:0]  upper;

  assign is_dram = (paddr_i >= `MC_DRAM_BASE);

  //////////////////////////////////////////////////
  // dram bank hash
  //////////////////////////////////////////////////

  // bank bits sit right above the block offset
  assign word_offset = paddr_i[2+:OFFSET_W];
  assign bank = paddr_i[2+OFFSET_W+:BANK_W];
  assign upper = paddr_i[`MC_PADDR_W-1:UPPER_LSB];

  always_comb
  begin
    if (is_dram)
    begin
      // top bank bit picks the row
      // vcache rows are just outside the tile array
      if (bank[BANK_W-1])
        y_o = `MC_Y_W'(`MC_NUM_TILES_Y + 1);
      else
        y_o = '0;
      // column 0 is not a vcache, hence the plus one
      x_o = `MC_X_W'(bank[BANK_W-2:0]) + `MC_X_W'(1);
      // bank bits drop out of the word address
      addr_o = `MC_ADDR_W'({upper, word_offset});
    end
    else
    begin
      // tile space
      // coordinates come straight from the address
      y_o = paddr_i[27:24];
      x_o = paddr_i[23:20];
      addr_o = `MC_ADDR_W'(paddr_i[19:2]);
    end
  end

endmodule

// ==== rtl/mc_bridge_macros.svh ====
`ifndef MC_BRIDGE_MACROS_SVH
`define MC_BRIDGE_MACROS_SVH

// processor side widths
`define MC_PADDR_W 32

// network packet widths
`define MC_DATA_W 32
`define MC_ADDR_W 28
`define MC_X_W 4
`define MC_Y_W 4

// number of transaction slots in flight
`define MC_MAX_OUT 4

// mesh geometry
// vcache banks sit on the top and bottom rows
`define MC_NUM_TILES_X 4
`define MC_NUM_TILES_Y 4
`define MC_VCACHE_BLOCK_WORDS 8

// anything at or above this goes to dram
`define MC_DRAM_BASE 32'h8000_0000

`endif

// ==== rtl/mc_bridge_pkg.sv ====
`include "mc_bridge_macros.svh"

package mc_bridge_pkg;

  // uncached command type from the processor
  typedef enum logic [0:0] {
    e_mem_rd = 1'b0,
    e_mem_wr = 1'b1
  } mem_msg_e;

  // access size in bytes
  typedef enum logic [1:0] {
    e_size_1 = 2'b00,
    e_size_2 = 2'b01,
    e_size_4 = 2'b10
  } msg_size_e;

  // network request opcodes
  typedef enum logic [1:0] {
    e_remote_load         = 2'd0,
    e_remote_store        = 2'd1,
    e_remote_masked_store = 2'd2
  } mc_op_e;

  // transaction slot index
  // also sent out as the packet reg id
  typedef logic [$clog2(`MC_MAX_OUT)-1:0] slot_id_t;

endpackage

// ==== rtl/mc_bridge_top.sv ====
`timescale 1ns/10ps

`include "mc_bridge_macros.svh"

module mc_bridge_top
  (input                                    clk_i
   , input                                  rst_i

   , input                                  cmd_v_i
   , input  mc_bridge_pkg::mem_msg_e        cmd_type_i
   , input  mc_bridge_pkg::msg_size_e       cmd_size_i
   , input  [`MC_PADDR_W-1:0]               cmd_addr_i
   , input  [`MC_DATA_W-1:0]                cmd_data_i
   , output logic                           cmd_ready_o

   , output logic                           out_v_o
   , output mc_bridge_pkg::mc_op_e          out_op_o
   , output logic [`MC_ADDR_W-1:0]          out_addr_o
   , output logic [`MC_DATA_W-1:0]          out_data_o
   , output logic [`MC_DATA_W/8-1:0]        out_mask_o
   , output mc_bridge_pkg::slot_id_t        out_reg_id_o
   , output logic [`MC_X_W-1:0]             out_x_o
   , output logic [`MC_Y_W-1:0]             out_y_o
   , input                                  out_ready_i

   , input                                  ret_v_i
   , input  mc_bridge_pkg::slot_id_t        ret_id_i
   , input  [`MC_DATA_W-1:0]                ret_data_i

   , output logic                           resp_v_o
   , output mc_bridge_pkg::mem_msg_e        resp_type_o
   , output mc_bridge_pkg::msg_size_e       resp_size_o
   , output logic [`MC_PADDR_W-1:0]         resp_addr_o
   , output logic [`MC_DATA_W-1:0]          resp_data_o
   , input                                  resp_yumi_i
   );

  import mc_bridge_pkg::*;

  logic [`MC_MAX_OUT-1:0] slot_alloc;
  logic [`MC_MAX_OUT-1:0] slot_release;
  logic [`MC_MAX_OUT-1:0] slot_busy;
  logic [`MC_MAX_OUT-1:0] slot_done;
  mem_msg_e               slot_type [`MC_MAX_OUT];
  msg_size_e              slot_size [`MC_MAX_OUT];
  logic [`MC_PADDR_W-1:0] slot_addr [`MC_MAX_OUT];
  logic [`MC_DATA_W-1:0]  slot_data [`MC_MAX_OUT];

  mc_cmd_dispatch dispatch
    (.clk_i, .rst_i
     , .cmd_v_i, .cmd_type_i, .cmd_size_i, .cmd_addr_i, .cmd_data_i, .cmd_ready_o
     , .out_ready_i, .slot_busy_i(slot_busy)
     , .out_v_o, .out_op_o, .out_addr_o, .out_data_o, .out_mask_o
     , .out_reg_id_o, .out_x_o, .out_y_o
     , .slot_alloc_o(slot_alloc)
     );

  // one record per reg id
  for (genvar i = 0; i < `MC_MAX_OUT; i++)
  begin : g_slot
    mc_txn_slot #(.SLOT_ID(i)) slot
      (.clk_i, .rst_i
       , .alloc_i(slot_alloc[i]), .alloc_type_i(cmd_type_i)
       , .alloc_size_i(cmd_size_i), .alloc_addr_i(cmd_addr_i)
       , .ret_v_i, .ret_id_i, .ret_data_i
       , .release_i(slot_release[i])
       , .busy_o(slot_busy[i]), .done_o(slot_done[i])
       , .type_o(slot_type[i]), .size_o(slot_size[i])
       , .addr_o(slot_addr[i]), .data_o(slot_data[i])
       );
  end

  mc_resp_collect collect
    (.clk_i, .rst_i
     , .slot_busy_i(slot_busy), .slot_done_i(slot_done)
     , .slot_type_i(slot_type), .slot_size_i(slot_size)
     , .slot_addr_i(slot_addr), .slot_data_i(slot_data)
     , .resp_v_o, .resp_type_o, .resp_size_o, .resp_addr_o, .resp_data_o
     , .resp_yumi_i
     , .slot_release_o(slot_release)
     );

endmodule

// ==== rtl/mc_cmd_dispatch.sv ====
`timescale 1ns/10ps

`include "mc_bridge_macros.svh"

module mc_cmd_dispatch
  (input                                    clk_i
   , input                                  rst_i

   , input                                  cmd_v_i
   , input  mc_bridge_pkg::mem_msg_e        cmd_type_i
   , input  mc_bridge_pkg::msg_size_e       cmd_size_i
   , input  [`MC_PADDR_W-1:0]               cmd_addr_i
   , input  [`MC_DATA_W-1:0]                cmd_data_i
   , output logic                           cmd_ready_o

   , input                                  out_ready_i
   , input  [`MC_MAX_OUT-1:0]               slot_busy_i

   , output logic                           out_v_o
   , output mc_bridge_pkg::mc_op_e          out_op_o
   , output logic [`MC_ADDR_W-1:0]          out_addr_o
   , output logic [`MC_DATA_W-1:0]          out_data_o
   , output logic [`MC_DATA_W/8-1:0]        out_mask_o
   , output mc_bridge_pkg::slot_id_t        out_reg_id_o
   , output logic [`MC_X_W-1:0]             out_x_o
   , output logic [`MC_Y_W-1:0]             out_y_o

   , output logic [`MC_MAX_OUT-1:0]         slot_alloc_o
   );

  import mc_bridge_pkg::*;

  slot_id_t                tail_r;
  logic                    accept;
  logic [1:0]              low_bits;
  logic [`MC_DATA_W/8-1:0] store_mask;

  mc_addr_xlate xlate
    (.paddr_i(cmd_addr_i)
     , .x_o(out_x_o)
     , .y_o(out_y_o)
     , .addr_o(out_addr_o)
     );

  //////////////////////////////////////////////////
  // slot allocation
  //////////////////////////////////////////////////

  // slots are handed out in command order
  assign cmd_ready_o = ~slot_busy_i[tail_r] & out_ready_i;
  assign accept = cmd_v_i & cmd_ready_o;
  assign out_v_o = accept;
  assign out_reg_id_o = tail_r;
  assign slot_alloc_o = accept ? (`MC_MAX_OUT'(1) << tail_r) : '0;

  always_ff @(posedge clk_i)
  begin
    if (rst_i)
      tail_r <= '0;
    else if (accept)
      tail_r <= tail_r + 1'b1;
  end

  //////////////////////////////////////////////////
  // packet build
  //////////////////////////////////////////////////

  assign low_bits = cmd_addr_i[1:0];

  always_comb
  begin
    case (cmd_size_i)
      e_size_1: store_mask = 4'h1 << low_bits;
      e_size_2: store_mask = 4'h3 << low_bits;
      default:  store_mask = 4'hf << low_bits;
    endcase
  end

  always_comb
  begin
    if (cmd_type_i == e_mem_rd)
    begin
      // load info travels in the payload
      out_op_o = e_remote_load;
      out_mask_o = '0;
      out_data_o = '0;
      out_data_o[0] = (cmd_size_i == e_size_1);
      out_data_o[1] = (cmd_size_i == e_size_2);
      out_data_o[3:2] = low_bits;
    end
    else
    begin
      // partial writes need the masked form
      out_op_o = (store_mask == '1) ? e_remote_store : e_remote_masked_store;
      out_mask_o = store_mask;
      out_data_o = cmd_data_i << {low_bits, 3'b000};
    end
  end

endmodule

// ==== rtl/mc_resp_collect.sv ====
`timescale 1ns/10ps

`include "mc_bridge_macros.svh"

module mc_resp_collect
  (input                                    clk_i
   , input                                  rst_i

   , input  [`MC_MAX_OUT-1:0]               slot_busy_i
   , input  [`MC_MAX_OUT-1:0]               slot_done_i
   , input  mc_bridge_pkg::mem_msg_e        slot_type_i [`MC_MAX_OUT]
   , input  mc_bridge_pkg::msg_size_e       slot_size_i [`MC_MAX_OUT]
   , input  [`MC_PADDR_W-1:0]               slot_addr_i [`MC_MAX_OUT]
   , input  [`MC_DATA_W-1:0]                slot_data_i [`MC_MAX_OUT]

   , output logic                           resp_v_o
   , output mc_bridge_pkg::mem_msg_e        resp_type_o
   , output mc_bridge_pkg::msg_size_e       resp_size_o
   , output logic [`MC_PADDR_W-1:0]         resp_addr_o
   , output logic [`MC_DATA_W-1:0]          resp_data_o
   , input                                  resp_yumi_i

   , output logic [`MC_MAX_OUT-1:0]         slot_release_o
   );

  import mc_bridge_pkg::*;

  slot_id_t              head_r;
  logic                  head_ready;
  logic [`MC_DATA_W-1:0] head_data;

  // head slot has its reply and nothing is pending
  assign head_ready = slot_busy_i[head_r] & slot_done_i[head_r] & ~resp_v_o;

  // trim the returned word to the access size
  always_comb
  begin
    case (slot_size_i[head_r])
      e_size_1: head_data = `MC_DATA_W'(slot_data_i[head_r][7:0]);
      e_size_2: head_data = `MC_DATA_W'(slot_data_i[head_r][15:0]);
      default:  head_data = slot_data_i[head_r];
    endcase
  end

  always_ff @(posedge clk_i)
  begin
    if (rst_i)
    begin
      resp_v_o <= 1'b0;
      head_r <= '0;
    end
    else if (resp_yumi_i)
    begin
      resp_v_o <= 1'b0;
      head_r <= head_r + 1'b1;
    end
    else if (head_ready)
      resp_v_o <= 1'b1;
  end

  always_ff @(posedge clk_i)
  begin
    if (head_ready)
    begin
      resp_type_o <= slot_type_i[head_r];
      resp_size_o <= slot_size_i[head_r];
      resp_addr_o <= slot_addr_i[head_r];
      resp_data_o <= head_data;
    end
  end

  // free the head on the same edge it is consumed
  assign slot_release_o = resp_yumi_i ? (`MC_MAX_OUT'(1) << head_r) : '0;

endmodule

// ==== rtl/mc_txn_slot.sv ====
`timescale 1ns/10ps

`include "mc_bridge_macros.svh"

module mc_txn_slot
  #(parameter int SLOT_ID = 0)
  (input                                    clk_i
   , input                                  rst_i

   , input                                  alloc_i
   , input  mc_bridge_pkg::mem_msg_e        alloc_type_i
   , input  mc_bridge_pkg::msg_size_e       alloc_size_i
   , input  [`MC_PADDR_W-1:0]               alloc_addr_i

   , input                                  ret_v_i
   , input  mc_bridge_pkg::slot_id_t        ret_id_i
   , input  [`MC_DATA_W-1:0]                ret_data_i

   , input                                  release_i

   , output logic                           busy_o
   , output logic                           done_o
   , output mc_bridge_pkg::mem_msg_e        type_o
   , output mc_bridge_pkg::msg_size_e       size_o
   , output logic [`MC_PADDR_W-1:0]         addr_o
   , output logic [`MC_DATA_W-1:0]          data_o
   );

  import mc_bridge_pkg::*;

  logic ret_hit;

  // only a busy slot can own a reply
  assign ret_hit = ret_v_i & busy_o & (ret_id_i == slot_id_t'(SLOT_ID));

  always_ff @(posedge clk_i)
  begin
    if (rst_i | release_i)
    begin
      busy_o <= 1'b0;
      done_o <= 1'b0;
    end
    else if (alloc_i)
    begin
      busy_o <= 1'b1;
      done_o <= 1'b0;
    end
    else if (ret_hit)
      done_o <= 1'b1;
  end

  // header and returned data
  always_ff @(posedge clk_i)
  begin
    if (alloc_i)
    begin
      type_o <= alloc_type_i;
      size_o <= alloc_size_i;
      addr_o <= alloc_addr_i;
    end
    // store replies carry nothing useful
    if (ret_hit)
      data_o <= (type_o == e_mem_rd) ? ret_data_i : '0;
  end

endmodule

// ==== sim/mc_bridge_assertions.sv ====
`timescale 1ns/10ps

`include "mc_bridge_macros.svh"

module mc_bridge_assertions
  (input                             clk_i
   , input                           rst_i
   , input                           out_v_i
   , input                           out_ready_i
   , input                           cmd_ready_i
   , input [`MC_MAX_OUT-1:0]         slot_busy_i
   , input                           resp_v_i
   , input                           resp_yumi_i
   , input [`MC_PADDR_W-1:0]         resp_addr_i
   , input [`MC_DATA_W-1:0]          resp_data_i
   , input [2:0]                     resp_info_i
   );

  // packets only leave when the network can take them
  a_out_ready: assert property (@(posedge clk_i) disable iff (rst_i)
    out_v_i |-> out_ready_i)
    else $error("packet sent while network not ready");

  a_resp_stable: assert property (@(posedge clk_i) disable iff (rst_i)
    resp_v_i && !resp_yumi_i |=>
      $stable(resp_addr_i) && $stable(resp_data_i) && $stable(resp_info_i))
    else $error("response fields changed before yumi");

  a_full_stall: assert property (@(posedge clk_i) disable iff (rst_i)
    (&slot_busy_i) |-> !cmd_ready_i)
    else $error("command ready with every slot busy");

  a_reset_quiet: assert property (@(posedge clk_i)
    rst_i |=> !resp_v_i)
    else $error("response valid right after reset");

endmodule

bind mc_bridge_top mc_bridge_assertions chk
  (.clk_i, .rst_i
   , .out_v_i(out_v_o), .out_ready_i
   , .cmd_ready_i(cmd_ready_o), .slot_busy_i(slot_busy)
   , .resp_v_i(resp_v_o), .resp_yumi_i
   , .resp_addr_i(resp_addr_o), .resp_data_i(resp_data_o)
   , .resp_info_i({resp_type_o, resp_size_o})
   );

// ==== sim/mc_bridge_tb.sv ====
`timescale 1ns/10ps

`include "mc_bridge_macros.svh"

module mc_bridge_tb;

  import mc_bridge_pkg::*;

  localparam int NUM_CMDS = 20;
  localparam int TIMEOUT = 400;

  typedef struct packed {
    mem_msg_e                typ;
    msg_size_e               siz;
    logic [31:0]             addr;
    logic [31:0]             data;
    mc_op_e                  op;
    logic [3:0]              x;
    logic [3:0]              y;
    logic [27:0]             eaddr;
    logic [3:0]              mask;
    logic [31:0]             edata;
  } cmd_row_t;

  logic clk_i;
  logic rst_i;
  logic cmd_v_i;
  mem_msg_e cmd_type_i;
  msg_size_e cmd_size_i;
  logic [31:0] cmd_addr_i;
  logic [31:0] cmd_data_i;
  logic cmd_ready_o;
  logic out_v_o;
  mc_op_e out_op_o;
  logic [27:0] out_addr_o;
  logic [31:0] out_data_o;
  logic [3:0] out_mask_o;
  slot_id_t out_reg_id_o;
  logic [3:0] out_x_o;
  logic [3:0] out_y_o;
  logic out_ready_i;
  logic ret_v_i;
  slot_id_t ret_id_i;
  logic [31:0] ret_data_i;
  logic resp_v_o;
  mem_msg_e resp_type_o;
  msg_size_e resp_size_o;
  logic [31:0] resp_addr_o;
  logic [31:0] resp_data_o;
  logic resp_yumi_i;

  cmd_row_t tbl [NUM_CMDS];
  int errors = 0;
  int cycle = 0;
  // commands taken since reset, slots are handed out in this order
  int accepted = 0;
  logic [31:0] lcg_state = 32'd9942;
  // network model state per reg id
  logic pend [`MC_MAX_OUT];
  int due [`MC_MAX_OUT];
  logic [31:0] rdata [`MC_MAX_OUT];
  logic net_hold = 1'b0;
  logic sent;
  // response consumer state
  logic yumi_en = 1'b1;
  logic take_next = 1'b0;
  logic [31:0] exp_type_q [$];
  logic [31:0] exp_size_q [$];
  logic [31:0] exp_addr_q [$];
  logic [31:0] exp_data_q [$];

  mc_bridge_top uut (.*);

  initial
  begin
    clk_i = 1'b0;
    forever #2 clk_i = ~clk_i;
  end

  //////////////////////////////////////////////////
  // helpers
  //////////////////////////////////////////////////

  function automatic logic [31:0] lcg_next();
    lcg_state = lcg_state * 32'd1103515245 + 32'd12345;
    return lcg_state >> 16;
  endfunction

  function automatic logic [31:0] trim_to_size(logic [31:0] d, msg_size_e s);
    if (s == e_size_1)
      return {24'h0, d[7:0]};
    else if (s == e_size_2)
      return {16'h0, d[15:0]};
    return d;
  endfunction

  task automatic check(string name, logic [31:0] got, logic [31:0] exp);
    if (got !== exp)
    begin
      $display("Fail at %0t: %s got %h expected %h", $time, name, got, exp);
      errors++;
    end
  endtask

  task automatic load_table();
    // tile space reads
    tbl[0] = '{e_mem_rd, e_size_4, 32'h0312_3458, 32'h0, e_remote_load,
               4'd1, 4'd3, 28'h0008d16, 4'h0, 32'h0};
    tbl[1] = '{e_mem_rd, e_size_1, 32'h0120_0007, 32'h0, e_remote_load,
               4'd2, 4'd1, 28'h0000001, 4'h0, 32'hd};
    tbl[2] = '{e_mem_rd, e_size_2, 32'h0230_0102, 32'h0, e_remote_load,
               4'd3, 4'd2, 28'h0000040, 4'h0, 32'ha};
    // one dram read per bank
    // word offset matches the bank
    tbl[3] = '{e_mem_rd, e_size_4, 32'h8000_1000, 32'h0, e_remote_load,
               4'd1, 4'd0, 28'h4000080, 4'h0, 32'h0};
    tbl[4] = '{e_mem_rd, e_size_4, 32'h8000_1024, 32'h0, e_remote_load,
               4'd2, 4'd0, 28'h4000081, 4'h0, 32'h0};
    tbl[5] = '{e_mem_rd, e_size_4, 32'h8000_1048, 32'h0, e_remote_load,
               4'd3, 4'd0, 28'h4000082, 4'h0, 32'h0};
    tbl[6] = '{e_mem_rd, e_size_4, 32'h8000_106c, 32'h0, e_remote_load,
               4'd4, 4'd0, 28'h4000083, 4'h0, 32'h0};
    tbl[7] = '{e_mem_rd, e_size_4, 32'h8000_1090, 32'h0, e_remote_load,
               4'd1, 4'd5, 28'h4000084, 4'h0, 32'h0};
    tbl[8] = '{e_mem_rd, e_size_4, 32'h8000_10b4, 32'h0, e_remote_load,
               4'd2, 4'd5, 28'h4000085, 4'h0, 32'h0};
    tbl[9] = '{e_mem_rd, e_size_4, 32'h8000_10d8, 32'h0, e_remote_load,
               4'd3, 4'd5, 28'h4000086, 4'h0, 32'h0};
    tbl[10] = '{e_mem_rd, e_size_4, 32'h8000_10fc, 32'h0, e_remote_load,
                4'd4, 4'd5, 28'h4000087, 4'h0, 32'h0};
    // writes at each low offset
    tbl[11] = '{e_mem_wr, e_size_1, 32'h0110_0040, 32'ha1b2c3d4, e_remote_masked_store,
                4'd1, 4'd1, 28'h10, 4'h1, 32'ha1b2c3d4};
    tbl[12] = '{e_mem_wr, e_size_1, 32'h0110_0041, 32'ha1b2c3d4, e_remote_masked_store,
                4'd1, 4'd1, 28'h10, 4'h2, 32'hb2c3d400};
    tbl[13] = '{e_mem_wr, e_size_1, 32'h0110_0042, 32'ha1b2c3d4, e_remote_masked_store,
                4'd1, 4'd1, 28'h10, 4'h4, 32'hc3d40000};
    tbl[14] = '{e_mem_wr, e_size_1, 32'h0110_0043, 32'ha1b2c3d4, e_remote_masked_store,
                4'd1, 4'd1, 28'h10, 4'h8, 32'hd4000000};
    tbl[15] = '{e_mem_wr, e_size_2, 32'h0110_0040, 32'ha1b2c3d4, e_remote_masked_store,
                4'd1, 4'd1, 28'h10, 4'h3, 32'ha1b2c3d4};
    tbl[16] = '{e_mem_wr, e_size_2, 32'h0110_0042, 32'ha1b2c3d4, e_remote_masked_store,
                4'd1, 4'd1, 28'h10, 4'hc, 32'hc3d40000};
    tbl[17] = '{e_mem_wr, e_size_2, 32'h0110_0043, 32'ha1b2c3d4, e_remote_masked_store,
                4'd1, 4'd1, 28'h10, 4'h8, 32'hd4000000};
    tbl[18] = '{e_mem_wr, e_size_4, 32'h0110_0040, 32'ha1b2c3d4, e_remote_store,
                4'd1, 4'd1, 28'h10, 4'hf, 32'ha1b2c3d4};
    tbl[19] = '{e_mem_wr, e_size_4, 32'h0110_0041, 32'ha1b2c3d4, e_remote_masked_store,
                4'd1, 4'd1, 28'h10, 4'he, 32'hb2c3d400};
  endtask

  // drive one row, wait for acceptance and check the packet
  task automatic apply_cmd(int i);
    int n;
    n = 0;
    @(posedge clk_i);
    cmd_v_i <= 1'b1;
    cmd_type_i <= tbl[i].typ;
    cmd_size_i <= tbl[i].siz;
    cmd_addr_i <= tbl[i].addr;
    cmd_data_i <= tbl[i].data;
    @(negedge clk_i);
    while (!cmd_ready_o && n < TIMEOUT)
    begin
      @(negedge clk_i);
      n++;
    end
    if (n >= TIMEOUT)
    begin
      $display("command %0d was never accepted", i);
      errors++;
    end
    else
    begin
      check("out_v_o", out_v_o, 1);
      check("out_op_o", out_op_o, tbl[i].op);
      check("out_x_o", out_x_o, tbl[i].x);
      check("out_y_o", out_y_o, tbl[i].y);
      check("out_addr_o", out_addr_o, tbl[i].eaddr);
      check("out_data_o", out_data_o, tbl[i].edata);
      check("out_reg_id_o", out_reg_id_o, accepted % `MC_MAX_OUT);
      accepted++;
      if (tbl[i].typ == e_mem_wr)
        check("out_mask_o", out_mask_o, tbl[i].mask);
      exp_type_q.push_back(tbl[i].typ);
      exp_size_q.push_back(tbl[i].siz);
      exp_addr_q.push_back(tbl[i].addr);
      if (tbl[i].typ == e_mem_rd)
        exp_data_q.push_back(trim_to_size({4'h0, tbl[i].eaddr} ^ 32'h5a5a_0000,
                                          tbl[i].siz));
      else
        exp_data_q.push_back(32'h0);
    end
    @(posedge clk_i);
    cmd_v_i <= 1'b0;
  endtask

  task automatic wait_drain();
    int n;
    n = 0;
    @(negedge clk_i);
    while ((exp_type_q.size() != 0 || resp_v_o) && n < TIMEOUT)
    begin
      @(negedge clk_i);
      n++;
    end
    if (n >= TIMEOUT)
    begin
      $display("responses did not all come back in time");
      errors++;
    end
  endtask

  //////////////////////////////////////////////////
  // network model
  //////////////////////////////////////////////////

  always @(negedge clk_i)
  begin
    if (out_v_o)
    begin
      pend[out_reg_id_o] = 1'b1;
      due[out_reg_id_o] = cycle + int'(lcg_next() % 6) + 1;
      rdata[out_reg_id_o] = (out_op_o == e_remote_load) ?
                            ({4'h0, out_addr_o} ^ 32'h5a5a_0000) : 32'hdead_beef;
    end
  end

  always @(posedge clk_i)
  begin
    cycle++;
    ret_v_i <= 1'b0;
    sent = 1'b0;
    if (!rst_i && !net_hold)
      for (int k = 0; k < `MC_MAX_OUT; k++)
        if (!sent && pend[k] && due[k] <= cycle)
        begin
          ret_v_i <= 1'b1;
          ret_id_i <= slot_id_t'(k);
          ret_data_i <= rdata[k];
          pend[k] = 1'b0;
          sent = 1'b1;
        end
  end

  //////////////////////////////////////////////////
  // response consumer
  //////////////////////////////////////////////////

  always @(negedge clk_i)
  begin
    if (yumi_en && resp_v_o && !resp_yumi_i)
    begin
      if (exp_type_q.size() == 0)
      begin
        $display("response arrived with no command outstanding");
        errors++;
      end
      else
      begin
        check("resp_type_o", resp_type_o, exp_type_q.pop_front());
        check("resp_size_o", resp_size_o, exp_size_q.pop_front());
        check("resp_addr_o", resp_addr_o, exp_addr_q.pop_front());
        check("resp_data_o", resp_data_o, exp_data_q.pop_front());
      end
      take_next = 1'b1;
    end
  end

  always @(posedge clk_i)
  begin
    resp_yumi_i <= take_next;
    take_next = 1'b0;
  end

  //////////////////////////////////////////////////
  // main sequence
  //////////////////////////////////////////////////

  initial
  begin
    logic [31:0] held_addr;
    logic [31:0] held_data;
    logic [31:0] held_type;
    logic [31:0] held_size;
    int n;
    rst_i = 1'b1;
    cmd_v_i = 1'b0;
    cmd_type_i = e_mem_rd;
    cmd_size_i = e_size_4;
    cmd_addr_i = '0;
    cmd_data_i = '0;
    out_ready_i = 1'b1;
    ret_v_i = 1'b0;
    ret_id_i = '0;
    ret_data_i = '0;
    resp_yumi_i = 1'b0;
    for (int k = 0; k < `MC_MAX_OUT; k++)
      pend[k] = 1'b0;
    load_table();
    repeat (3) @(posedge clk_i);
    rst_i <= 1'b0;

    // packets and in-order responses with random reply delay
    for (int i = 0; i < NUM_CMDS; i++)
      apply_cmd(i);
    wait_drain();

    // network not ready so nothing may leave
    @(posedge clk_i);
    out_ready_i <= 1'b0;
    cmd_v_i <= 1'b1;
    cmd_type_i <= tbl[0].typ;
    cmd_size_i <= tbl[0].siz;
    cmd_addr_i <= tbl[0].addr;
    cmd_data_i <= tbl[0].data;
    repeat (4)
    begin
      @(negedge clk_i);
      check("cmd_ready_o", cmd_ready_o, 0);
      check("out_v_o", out_v_o, 0);
    end
    @(posedge clk_i);
    cmd_v_i <= 1'b0;
    out_ready_i <= 1'b1;

    // back-pressure with replies and yumi withheld
    @(negedge clk_i);
    net_hold = 1'b1;
    yumi_en = 1'b0;
    for (int i = 0; i < 4; i++)
      apply_cmd(i);
    @(posedge clk_i);
    cmd_v_i <= 1'b1;
    cmd_addr_i <= tbl[4].addr;
    repeat (8)
    begin
      @(negedge clk_i);
      check("cmd_ready_o", cmd_ready_o, 0);
    end
    @(posedge clk_i);
    cmd_v_i <= 1'b0;

    @(negedge clk_i);
    net_hold = 1'b0;
    n = 0;
    while (!resp_v_o && n < TIMEOUT)
    begin
      @(negedge clk_i);
      n++;
    end
    if (n >= TIMEOUT)
    begin
      $display("no response appeared after replies were released");
      errors++;
    end
    held_addr = resp_addr_o;
    held_data = resp_data_o;
    held_type = resp_type_o;
    held_size = resp_size_o;
    // fields must hold while yumi stays low
    repeat (6)
    begin
      @(negedge clk_i);
      check("resp_v_o", resp_v_o, 1);
      check("resp_addr_o", resp_addr_o, held_addr);
      check("resp_data_o", resp_data_o, held_data);
      check("resp_type_o", resp_type_o, held_type);
      check("resp_size_o", resp_size_o, held_size);
    end
    yumi_en = 1'b1;
    wait_drain();

    $display("errors: %0d", errors);
    if (errors == 0)
      $display("All tests passed");
    else
      $display("Some tests failed");
    $finish;
  end

endmodule

// ==== tb.f ====
+incdir+rtl
rtl/mc_bridge_pkg.sv
rtl/mc_addr_xlate.sv
rtl/mc_cmd_dispatch.sv
rtl/mc_txn_slot.sv
rtl/mc_resp_collect.sv
rtl/mc_bridge_top.sv
sim/mc_bridge_assertions.sv
sim/mc_bridge_tb.sv
